// File: source/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// clk cycles per sck period, even and at least 2
`define LCD_SCK_DIV 4

// bits per serial frame, the byte sits in the low 8 bits
`define LCD_FRAME_BITS 16

// entries in the power-up command table
`define LCD_INIT_LEN 4

`endif

// File: source/lcd_pkg.sv
package lcd_pkg;

  // kind of item handed over by the host
  typedef enum logic [1:0] {
    CMD   = 2'd0,
    PARAM = 2'd1,
    PIXEL = 2'd2
  } item_kind_e;

  // one RGB565 word, seen as colour fields or as the two bytes sent on the wire
  typedef union packed {
    struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
    } fields;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } pixel565_u;

endpackage

// File: source/lcd_item_source.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_item_source (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   host_req,
  input  lcd_pkg::item_kind_e    host_kind,
  input  logic [23:0]            host_value,
  output logic                   host_ack,
  output logic                   src_req,
  output lcd_pkg::item_kind_e    src_kind,
  output logic [23:0]            src_value,
  input  logic                   src_ack,
  output logic                   init_done
);

  localparam int IDX_W = (`LCD_INIT_LEN > 2) ? $clog2(`LCD_INIT_LEN) : 1;

  localparam logic [1:0] P_IDLE = 2'd0;
  localparam logic [1:0] P_REQ  = 2'd1;
  localparam logic [1:0] P_REL  = 2'd2;
  localparam logic [1:0] P_HACK = 2'd3;

  logic [1:0]          phase;
  logic [IDX_W-1:0]    init_idx;
  lcd_pkg::item_kind_e init_kind;
  logic [7:0]          init_byte;

  // power-up sequence: sleep out, pixel format 16 bpp, display on
  always_comb
  begin
    case (init_idx)
      IDX_W'(0): begin init_kind = lcd_pkg::CMD;   init_byte = 8'h11; end
      IDX_W'(1): begin init_kind = lcd_pkg::CMD;   init_byte = 8'h3A; end
      IDX_W'(2): begin init_kind = lcd_pkg::PARAM; init_byte = 8'h55; end
      default:   begin init_kind = lcd_pkg::CMD;   init_byte = 8'h29; end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase     <= P_IDLE;
      init_idx  <= '0;
      init_done <= 1'b0;
      src_req   <= 1'b0;
      host_ack  <= 1'b0;
    end
    else
    begin
      case (phase)
        P_IDLE:
        begin
          if (!init_done)
          begin
            src_kind  <= init_kind;
            src_value <= {16'h0000, init_byte};
            src_req   <= 1'b1;
            phase     <= P_REQ;
          end
          else if (host_req)
          begin
            src_kind  <= host_kind;
            src_value <= host_value;
            src_req   <= 1'b1;
            phase     <= P_REQ;
          end
        end
        P_REQ:
        begin
          if (src_ack)
          begin
            src_req <= 1'b0;
            phase   <= P_REL;
          end
        end
        P_REL:
        begin
          // splitter has released its ack, the item is fully out
          if (!src_ack)
          begin
            if (!init_done)
            begin
              if (init_idx == IDX_W'(`LCD_INIT_LEN - 1))
                init_done <= 1'b1;
              else
                init_idx <= init_idx + 1'b1;
              phase <= P_IDLE;
            end
            else
            begin
              host_ack <= 1'b1;
              phase    <= P_HACK;
            end
          end
        end
        default:
        begin
          if (!host_req)
          begin
            host_ack <= 1'b0;
            phase    <= P_IDLE;
          end
        end
      endcase
    end
  end

  // host must hold its item steady until it is acknowledged
  assert property (@(posedge clk) disable iff (rst)
    (host_req && !host_ack) ##1 (host_req && !host_ack) |-> $stable(host_kind));

endmodule

// File: source/lcd_byte_splitter.sv
`timescale 1ns/10ps

module lcd_byte_splitter (
  input  logic                clk,
  input  logic                rst,
  input  logic                src_req,
  input  lcd_pkg::item_kind_e src_kind,
  input  logic [23:0]         src_value,
  output logic                src_ack,
  output logic                byte_req,
  output logic                byte_dc,
  output logic [7:0]          byte_data,
  input  logic                byte_ack
);

  localparam logic [1:0] P_IDLE = 2'd0;
  localparam logic [1:0] P_REQ  = 2'd1;
  localparam logic [1:0] P_REL  = 2'd2;
  localparam logic [1:0] P_DONE = 2'd3;

  logic [1:0]         phase;
  logic               byte_idx;
  lcd_pkg::pixel565_u pix;

  // keep the top bits of each colour channel
  always_comb
  begin
    pix.fields.r = src_value[23:19];
    pix.fields.g = src_value[15:10];
    pix.fields.b = src_value[7:3];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase    <= P_IDLE;
      byte_idx <= 1'b0;
      byte_req <= 1'b0;
      src_ack  <= 1'b0;
    end
    else
    begin
      case (phase)
        P_IDLE:
        begin
          if (src_req)
          begin
            byte_idx  <= 1'b0;
            byte_dc   <= (src_kind != lcd_pkg::CMD);
            byte_data <= (src_kind == lcd_pkg::PIXEL) ? pix.bytes.hi : src_value[7:0];
            byte_req  <= 1'b1;
            phase     <= P_REQ;
          end
        end
        P_REQ:
        begin
          if (byte_ack)
          begin
            byte_req <= 1'b0;
            phase    <= P_REL;
          end
        end
        P_REL:
        begin
          if (!byte_ack)
          begin
            // a pixel still owes its low byte
            if (src_kind == lcd_pkg::PIXEL && !byte_idx)
            begin
              byte_idx  <= 1'b1;
              byte_data <= pix.bytes.lo;
              byte_req  <= 1'b1;
              phase     <= P_REQ;
            end
            else
            begin
              src_ack <= 1'b1;
              phase   <= P_DONE;
            end
          end
        end
        default:
        begin
          if (!src_req)
          begin
            src_ack <= 1'b0;
            phase   <= P_IDLE;
          end
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) $rose(byte_req) |-> !byte_ack);

endmodule

// File: source/lcd_sck_gen.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_sck_gen (
  input  logic clk,
  input  logic rst,
  output logic tick,
  output logic sck
);

  localparam int DIV   = `LCD_SCK_DIV;
  localparam int CNT_W = $clog2(DIV);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  assign cnt_next = (cnt == CNT_W'(DIV - 1)) ? '0 : cnt + 1'b1;

  // tick and sck are registered so the pin stays glitch free
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt  <= CNT_W'(DIV - 1);
      tick <= 1'b0;
      sck  <= 1'b0;
    end
    else
    begin
      cnt  <= cnt_next;
      tick <= (cnt_next == '0);
      sck  <= (cnt_next >= CNT_W'(DIV / 2));
    end
  end

endmodule

// File: source/lcd_spi_tx.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_spi_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tick,
  input  logic       byte_req,
  input  logic       byte_dc,
  input  logic [7:0] byte_data,
  output logic       byte_ack,
  output logic       bus_req,
  input  logic       bus_ack,
  output logic       cs,
  output logic       dc,
  output logic       mosi
);

  localparam int FB    = `LCD_FRAME_BITS;
  localparam int CNT_W = $clog2(FB + 1);

  localparam logic [1:0] P_IDLE  = 2'd0;
  localparam logic [1:0] P_REQ   = 2'd1;
  localparam logic [1:0] P_SHIFT = 2'd2;
  localparam logic [1:0] P_ACK   = 2'd3;

  logic [1:0]       phase;
  logic             grant;
  logic [CNT_W-1:0] bit_cnt;
  logic [FB-1:0]    frame;
  logic [FB-1:0]    shreg;

  // upper frame bits are always zero
  assign frame = {{(FB - 8){1'b0}}, byte_data};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase    <= P_IDLE;
      grant    <= 1'b0;
      bit_cnt  <= '0;
      byte_ack <= 1'b0;
      bus_req  <= 1'b0;
      cs       <= 1'b1;
      dc       <= 1'b0;
      mosi     <= 1'b0;
    end
    else
    begin
      // the arbiter may answer between ticks, so hold on to it
      if (bus_req && bus_ack)
        grant <= 1'b1;

      if (phase == P_ACK)
      begin
        if (!byte_req)
        begin
          byte_ack <= 1'b0;
          phase    <= P_IDLE;
        end
      end
      else if (tick)
      begin
        case (phase)
          P_IDLE:
          begin
            if (byte_req)
            begin
              bus_req <= 1'b1;
              phase   <= P_REQ;
            end
          end
          P_REQ:
          begin
            if (grant)
            begin
              grant   <= 1'b0;
              bus_req <= 1'b0;
              cs      <= 1'b0;
              dc      <= byte_dc;
              mosi    <= frame[FB-1];
              shreg   <= frame << 1;
              bit_cnt <= CNT_W'(1);
              phase   <= P_SHIFT;
            end
          end
          default:
          begin
            if (bit_cnt == CNT_W'(FB))
            begin
              cs       <= 1'b1;
              byte_ack <= 1'b1;
              phase    <= P_ACK;
            end
            else
            begin
              mosi    <= shreg[FB-1];
              shreg   <= shreg << 1;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        endcase
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $fell(cs) |-> (!cs throughout tick [-> FB]) ##1 cs);

endmodule

// File: source/lcd_spi_top.sv
`timescale 1ns/10ps

module lcd_spi_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                host_req,
  input  lcd_pkg::item_kind_e host_kind,
  input  logic [23:0]         host_value,
  output logic                host_ack,
  output logic                init_done,
  output logic                bus_req,
  input  logic                bus_ack,
  output logic                sck,
  output logic                cs,
  output logic                dc,
  output logic                mosi
);

  logic                src_req;
  logic                src_ack;
  lcd_pkg::item_kind_e src_kind;
  logic [23:0]         src_value;
  logic                byte_req;
  logic                byte_ack;
  logic                byte_dc;
  logic [7:0]          byte_data;
  logic                tick;

  lcd_item_source source0 (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_kind  (host_kind),
    .host_value (host_value),
    .host_ack   (host_ack),
    .src_req    (src_req),
    .src_kind   (src_kind),
    .src_value  (src_value),
    .src_ack    (src_ack),
    .init_done  (init_done)
  );

  lcd_byte_splitter splitter0 (
    .clk        (clk),
    .rst        (rst),
    .src_req    (src_req),
    .src_kind   (src_kind),
    .src_value  (src_value),
    .src_ack    (src_ack),
    .byte_req   (byte_req),
    .byte_dc    (byte_dc),
    .byte_data  (byte_data),
    .byte_ack   (byte_ack)
  );

  lcd_sck_gen sck_gen0 (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .sck        (sck)
  );

  lcd_spi_tx tx0 (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .byte_req   (byte_req),
    .byte_dc    (byte_dc),
    .byte_data  (byte_data),
    .byte_ack   (byte_ack),
    .bus_req    (bus_req),
    .bus_ack    (bus_ack),
    .cs         (cs),
    .dc         (dc),
    .mosi       (mosi)
  );

endmodule

// File: test/lcd_spi_tests.svh
`ifndef LCD_SPI_TESTS_SVH
`define LCD_SPI_TESTS_SVH

task automatic expect_frame(input logic dc_bit, input logic [7:0] data);
  begin
    exp_dc.push_back(dc_bit);
    exp_byte.push_back(data);
  end
endtask

// compare the frames captured since the last call
task automatic check_frames(input string what);
  int i;
  begin
    if (cap_byte.size() != exp_byte.size())
    begin
      failures++;
      $display("ERROR @%0t: %s: %0d frames seen, %0d expected",
               $time, what, cap_byte.size(), exp_byte.size());
    end
    for (i = checked; i < exp_byte.size() && i < cap_byte.size(); i++)
    begin
      if (cap_dc[i] !== exp_dc[i] || cap_byte[i] !== exp_byte[i])
      begin
        mismatches++;
        $display("MISMATCH @%0t: %s frame %0d is dc=%0b byte=%02h, expected dc=%0b byte=%02h",
                 $time, what, i, cap_dc[i], cap_byte[i], exp_dc[i], exp_byte[i]);
      end
    end
    checked = exp_byte.size();
  end
endtask

// one host handshake with req held a few cycles past ack
task automatic send_item(input lcd_pkg::item_kind_e kind, input logic [23:0] value,
                         input int hold);
  int i;
  begin
    @(negedge clk);
    host_kind   = kind;
    host_value  = value;
    host_req    = 1'b1;
    item_cycles = 0;
    while (!host_ack)
    begin
      @(negedge clk);
      item_cycles++;
    end
    if (cap_byte.size() != exp_byte.size())
    begin
      failures++;
      $display("ERROR @%0t: host_ack rose with %0d frames seen, %0d expected",
               $time, cap_byte.size(), exp_byte.size());
    end
    for (i = 0; i < hold; i++)
    begin
      @(negedge clk);
      if (!host_ack)
      begin
        failures++;
        $display("ERROR @%0t: host_ack fell while host_req was still high", $time);
      end
    end
    host_req = 1'b0;
    while (host_ack)
      @(negedge clk);
  end
endtask

task automatic rand_bits(input int n, output logic [23:0] v);
  int i;
  begin
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v          = {v[22:0], lfsr_state[16]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  end
endtask

task automatic test_init_sequence();
  begin
    // a command waits on the host port for the whole power-up sequence
    @(negedge clk);
    host_kind  = lcd_pkg::CMD;
    host_value = 24'h00002C;
    host_req   = 1'b1;
    while (!init_done)
    begin
      if (host_ack)
      begin
        failures++;
        $display("ERROR @%0t: host_ack rose before init finished", $time);
      end
      @(negedge clk);
    end
    expect_frame(1'b0, 8'h11);
    expect_frame(1'b0, 8'h3A);
    expect_frame(1'b1, 8'h55);
    expect_frame(1'b0, 8'h29);
    check_frames("init sequence");
    expect_frame(1'b0, 8'h2C);
    while (!host_ack)
      @(negedge clk);
    host_req = 1'b0;
    while (host_ack)
      @(negedge clk);
    check_frames("command held during init");
  end
endtask

task automatic test_cmd_param();
  begin
    // only bits 7:0 of the value reach the wire
    expect_frame(1'b0, 8'h36);
    send_item(lcd_pkg::CMD, 24'h5A5A36, 2);
    expect_frame(1'b1, 8'h48);
    send_item(lcd_pkg::PARAM, 24'hC3C348, 2);
    check_frames("command and parameter");
  end
endtask

task automatic test_pixels();
  logic [23:0] rgb;
  logic [15:0] word;
  int n;
  begin
    for (n = 0; n < 20; n++)
    begin
      rand_bits(24, rgb);
      word = {rgb[23:19], rgb[15:10], rgb[7:3]};
      expect_frame(1'b1, word[15:8]);
      expect_frame(1'b1, word[7:0]);
      send_item(lcd_pkg::PIXEL, rgb, 1);
    end
    check_frames("pixel conversion");
  end
endtask

task automatic test_host_protocol();
  int i;
  int seen;
  begin
    // magenta packs to f81f
    expect_frame(1'b1, 8'hF8);
    expect_frame(1'b1, 8'h1F);
    send_item(lcd_pkg::PIXEL, 24'hFF00FF, 20);
    seen = cap_byte.size();
    for (i = 0; i < 200; i++)
    begin
      @(negedge clk);
      if (!cs || bus_req || host_ack)
      begin
        failures++;
        $display("ERROR @%0t: bus or host port active with no host request", $time);
      end
    end
    if (cap_byte.size() != seen)
    begin
      failures++;
      $display("ERROR @%0t: frames appeared while the host was idle", $time);
    end
    check_frames("host protocol");
  end
endtask

task automatic test_back_pressure();
  begin
    arb_delay = 50;
    expect_frame(1'b0, 8'h2A);
    send_item(lcd_pkg::CMD, 24'h00002A, 1);
    // the grant wait comes on top of one whole frame
    if (item_cycles < arb_delay + FB * `LCD_SCK_DIV)
    begin
      failures++;
      $display("ERROR @%0t: item done in %0d cycles despite a late grant", $time, item_cycles);
    end
    expect_frame(1'b1, 8'h00);
    send_item(lcd_pkg::PARAM, 24'h000000, 1);
    expect_frame(1'b1, 8'h01);
    send_item(lcd_pkg::PARAM, 24'h000001, 1);
    // 12 34 56 packs to 11aa
    expect_frame(1'b1, 8'h11);
    expect_frame(1'b1, 8'hAA);
    send_item(lcd_pkg::PIXEL, 24'h123456, 1);
    arb_delay = 0;
    check_frames("bus back-pressure");
  end
endtask

`endif

// File: test/lcd_spi_tb.sv
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_spi_tb;

  localparam int FB = `LCD_FRAME_BITS;
  // frames sent by all tests together, and cycles spent waiting on the arbiter
  localparam int EXP_FRAMES = 54;
  localparam int ARB_WAIT   = 5 * 60;
  localparam int TIMEOUT    = EXP_FRAMES * (FB + 4) * `LCD_SCK_DIV + ARB_WAIT + 2500;

  logic                clk;
  logic                rst;
  logic                host_req;
  lcd_pkg::item_kind_e host_kind;
  logic [23:0]         host_value;
  logic                host_ack;
  logic                init_done;
  logic                bus_req;
  logic                bus_ack = 1'b0;
  logic                sck;
  logic                cs;
  logic                dc;
  logic                mosi;

  // frames seen on the wire and frames the tests expect
  logic       cap_dc[$];
  logic [7:0] cap_byte[$];
  logic       exp_dc[$];
  logic [7:0] exp_byte[$];

  int mismatches     = 0;
  int failures       = 0;
  int mon_errors     = 0;
  int arb_errors     = 0;
  int cycles         = 0;
  int arb_delay      = 0;
  int grants_given   = 0;
  int frames_started = 0;
  int checked        = 0;
  int item_cycles    = 0;
  int total;

  logic [16:0] lfsr_state;

  lcd_spi_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_kind  (host_kind),
    .host_value (host_value),
    .host_ack   (host_ack),
    .init_done  (init_done),
    .bus_req    (bus_req),
    .bus_ack    (bus_ack),
    .sck        (sck),
    .cs         (cs),
    .dc         (dc),
    .mosi       (mosi)
  );

  always #5 clk = ~clk;

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
  endfunction

  // bus arbiter, grants after arb_delay cycles of bus_req
  logic req_prev;
  int   wait_cnt;

  always @(negedge clk)
  begin
    if (rst)
    begin
      bus_ack  = 1'b0;
      req_prev = 1'b0;
      wait_cnt = 0;
    end
    else
    begin
      if (req_prev && !bus_req && !bus_ack)
      begin
        arb_errors++;
        $display("ERROR @%0t: bus_req dropped before the bus was granted", $time);
      end
      if (bus_req && !bus_ack)
      begin
        if (!cs)
        begin
          arb_errors++;
          $display("ERROR @%0t: CS went low while waiting for the bus grant", $time);
        end
        if (wait_cnt >= arb_delay)
        begin
          bus_ack = 1'b1;
          grants_given++;
          wait_cnt = 0;
        end
        else
          wait_cnt++;
      end
      else if (bus_ack && !bus_req)
        bus_ack = 1'b0;
      req_prev = bus_req;
    end
  end

  // serial monitor, a receiver samples on the rising sck edge while CS is low
  logic          sck_prev;
  logic          cs_prev;
  logic [FB-1:0] rx_shift;
  logic          rx_dc;
  int            rx_bits;

  always @(negedge clk)
  begin
    if (rst)
    begin
      sck_prev = 1'b0;
      cs_prev  = 1'b1;
      rx_shift = '0;
      rx_dc    = 1'b0;
      rx_bits  = 0;
    end
    else
    begin
      if (cs_prev && !cs)
      begin
        rx_shift = '0;
        rx_bits  = 0;
        frames_started++;
        if (frames_started > grants_given)
        begin
          mon_errors++;
          $display("ERROR @%0t: CS fell without a bus grant", $time);
        end
      end
      if (!cs && sck && !sck_prev)
      begin
        rx_shift = {rx_shift[FB-2:0], mosi};
        rx_dc    = dc;
        rx_bits++;
      end
      if (!cs_prev && cs)
      begin
        if (rx_bits != FB)
        begin
          mon_errors++;
          $display("ERROR @%0t: frame had %0d sck rises instead of %0d", $time, rx_bits, FB);
        end
        if (rx_shift[FB-1:8] != '0)
        begin
          mon_errors++;
          $display("MISMATCH @%0t: upper frame bits are %h, expected zero",
                   $time, rx_shift[FB-1:8]);
        end
        cap_dc.push_back(rx_dc);
        cap_byte.push_back(rx_shift[7:0]);
      end
      if (!cs && bus_req)
      begin
        mon_errors++;
        $display("ERROR @%0t: bus_req is high while CS is low", $time);
      end
      sck_prev = sck;
      cs_prev  = cs;
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
      $display(">>> FAIL");
      $finish;
    end
  end

  `include "lcd_spi_tests.svh"

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    host_req   = 1'b0;
    host_kind  = lcd_pkg::CMD;
    host_value = 24'h000000;
    lfsr_state = 17'd77415;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    test_init_sequence();
    test_cmd_param();
    test_pixels();
    test_host_protocol();
    test_back_pressure();
    repeat (10) @(negedge clk);

    total = mismatches + failures + mon_errors + arb_errors;
    $display("errors: mismatches=%0d checks=%0d monitor=%0d arbiter=%0d",
             mismatches, failures, mon_errors, arb_errors);
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
+incdir+test
source/lcd_pkg.sv
source/lcd_item_source.sv
source/lcd_byte_splitter.sv
source/lcd_sck_gen.sv
source/lcd_spi_tx.sv
source/lcd_spi_top.sv
test/lcd_spi_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the LCD SPI testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module lcd_spi_tb -f vlog.f -o lcd_spi_sim

status=0
./obj_dir/lcd_spi_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation finished without failure"
